//--- rx_adapt_defines.svh
/*
  Size constants for the receive width adapter. Included by the package,
  the symbol interface and every RTL block that sizes a word or a buffer.
*/
`ifndef RX_ADAPT_DEFINES_SVH
`define RX_ADAPT_DEFINES_SVH

// data bits carried by one decoded symbol
`define RX_SYM_BITS 8

// widest word on either side of the adapter, in symbols
`define RX_MAX_SYMS 4

// accumulator capacity in symbols, two full words so that one word can
// drain while the next one lands
`define RX_ACC_DEPTH (2 * `RX_MAX_SYMS)

`endif

//--- rx_adapt_pkg.sv
/*
  Shared types for the receive width adapter: the per-symbol status flags,
  the data byte and the symbol count used for configuration and word sizes.
*/
`default_nettype none

`include "rx_adapt_defines.svh"

package rx_adapt_pkg;

  // status flags that travel with every symbol from the 8b/10b decoder
  typedef struct packed {
    logic ctrl;
    logic disp_err;
    logic code_err;
    logic pat_det;
  } rx_status_t;

  // data part of one symbol
  typedef logic [`RX_SYM_BITS-1:0] rx_byte_t;

  // a count of symbols; legal values are 1 to RX_MAX_SYMS, 0 and the
  // values above the maximum mark a bad configuration
  typedef logic [2:0] sym_cnt_t;

endpackage

`default_nettype wire

//--- sym_word_if.sv
/*
  Valid/ready link carrying one word of symbols and its symbol count between
  the adapter blocks. The symbol type is a parameter so one link definition
  serves both the data bytes and the status flags.
*/
`timescale 1ns/1ps
`default_nettype none

`include "rx_adapt_defines.svh"

interface sym_word_if #(
  parameter type sym_t = rx_adapt_pkg::rx_byte_t
) ();

  logic                               valid;
  logic                               ready;
  rx_adapt_pkg::sym_cnt_t             cnt;
  // slot 0 holds the oldest symbol of the word
  sym_t [`RX_MAX_SYMS-1:0]            syms;

  // producer keeps valid, cnt and syms steady until ready is seen
  modport producer (
    output valid,
    output cnt,
    output syms,
    input  ready
  );

  modport consumer (
    input  valid,
    input  cnt,
    input  syms,
    output ready
  );

endinterface

`default_nettype wire

//--- rx_in_port.sv
/*
  Input side of the width adapter. Acts as a four-phase req/ack slave towards
  the decoder, captures one word into a holding register and offers it to the
  data and status gearboxes at the same time.
*/
`timescale 1ns/1ps
`default_nettype none

`include "rx_adapt_defines.svh"

module rx_in_port (
  input  logic                                          dataout_clk,
  input  logic                                          rst_outclk,
  input  logic                                          in_req,
  output logic                                          in_ack,
  input  rx_adapt_pkg::rx_byte_t   [`RX_MAX_SYMS-1:0]   datain,
  input  rx_adapt_pkg::rx_status_t [`RX_MAX_SYMS-1:0]   statin,
  input  rx_adapt_pkg::sym_cnt_t                        words_in,
  sym_word_if.producer                                  data_link,
  sym_word_if.producer                                  stat_link
);

  // holding means the handshake is done but the word has not left yet
  typedef enum logic [1:0] {
    s_idle,
    s_acked,
    s_holding
  } state_t;

  state_t                                        state_q;
  logic                                          full_q;
  logic                                          capture;
  logic                                          xfer;
  rx_adapt_pkg::rx_byte_t   [`RX_MAX_SYMS-1:0]   data_q;
  rx_adapt_pkg::rx_status_t [`RX_MAX_SYMS-1:0]   stat_q;
  rx_adapt_pkg::sym_cnt_t                        cnt_q;

  // a new request is taken only once the last handshake has closed
  assign capture = (state_q == s_idle) && in_req && !full_q;
  // both gearboxes take the word on the same edge
  assign xfer    = full_q && data_link.ready && stat_link.ready;
  assign in_ack  = (state_q == s_acked);

  always_ff @(posedge dataout_clk or posedge rst_outclk)
  begin
    if (rst_outclk)
    begin
      state_q <= s_idle;
      full_q  <= 1'b0;
    end
    else
    begin
      case (state_q)
        s_idle:
        begin
          if (capture)
            state_q <= s_acked;
        end
        s_acked:
        begin
          if (!in_req)
            state_q <= (full_q && !xfer) ? s_holding : s_idle;
        end
        s_holding:
        begin
          if (xfer)
            state_q <= s_idle;
        end
        default:
          state_q <= s_idle;
      endcase

      if (capture)
        full_q <= 1'b1;
      else if (xfer)
        full_q <= 1'b0;
    end
  end

  always_ff @(posedge dataout_clk)
  begin
    if (capture)
    begin
      data_q <= datain;
      stat_q <= statin;
      cnt_q  <= words_in;
    end
  end

  assign data_link.valid = full_q;
  assign data_link.cnt   = cnt_q;
  assign data_link.syms  = data_q;
  assign stat_link.valid = full_q;
  assign stat_link.cnt   = cnt_q;
  assign stat_link.syms  = stat_q;

  // the source keeps its request up until it has seen the acknowledge
  a_req_until_ack: assert property (@(posedge dataout_clk) disable iff (rst_outclk)
    in_req && !in_ack |=> in_req);

  // both gearboxes run in lockstep, so their readys never disagree
  a_ready_lockstep: assert property (@(posedge dataout_clk) disable iff (rst_outclk)
    data_link.ready == stat_link.ready);

endmodule

`default_nettype wire

//--- symbol_gearbox.sv
/*
  Symbol accumulator that repacks words of one symbol count into words of
  another. The symbol type is a parameter; the adapter runs one instance for
  the data bytes and one for the status flags, fed with identical counts.
*/
`timescale 1ns/1ps
`default_nettype none

`include "rx_adapt_defines.svh"

module symbol_gearbox #(
  parameter type sym_t = rx_adapt_pkg::rx_byte_t
) (
  input  logic                   dataout_clk,
  input  logic                   rst_outclk,
  input  rx_adapt_pkg::sym_cnt_t words_out,
  sym_word_if.consumer           in_link,
  sym_word_if.producer           out_link,
  output logic                   cfg_error
);

  localparam int fill_w = $clog2(`RX_ACC_DEPTH + 1);

  sym_t [`RX_ACC_DEPTH-1:0] acc_q;
  sym_t [`RX_ACC_DEPTH-1:0] acc_nxt;
  logic [fill_w-1:0]        fill_q;
  logic [fill_w-1:0]        fill_nxt;
  logic                     accept;
  logic                     emit;
  logic                     room;

  function automatic logic cnt_bad(input rx_adapt_pkg::sym_cnt_t c);
    return (c == '0) || (c > `RX_MAX_SYMS);
  endfunction

  // the input count is only known while a word is offered
  assign cfg_error = cnt_bad(words_out) || (in_link.valid && cnt_bad(in_link.cnt));

  assign room   = (int'(fill_q) + int'(in_link.cnt)) <= `RX_ACC_DEPTH;
  assign in_link.ready  = in_link.valid && !cfg_error && room;
  assign out_link.valid = !cfg_error && (fill_q >= words_out);
  assign out_link.cnt   = words_out;
  // slots at and above words_out are padded downstream
  assign out_link.syms  = acc_q[`RX_MAX_SYMS-1:0];

  assign accept = in_link.valid && in_link.ready;
  assign emit   = out_link.valid && out_link.ready;

  // drop the emitted symbols from the bottom, then append the new word
  // right after whatever is left
  always_comb
  begin
    int shift;
    int base;
    int in_cnt;

    shift  = emit ? int'(words_out) : 0;
    base   = int'(fill_q) - shift;
    in_cnt = accept ? int'(in_link.cnt) : 0;

    for (int k = 0; k < `RX_ACC_DEPTH; k++)
    begin
      if (k + shift < `RX_ACC_DEPTH)
        acc_nxt[k] = acc_q[k + shift];
      else
        acc_nxt[k] = acc_q[k];

      if ((k >= base) && (k < base + in_cnt))
        acc_nxt[k] = in_link.syms[k - base];
    end

    fill_nxt = fill_w'(base + in_cnt);
  end

  always_ff @(posedge dataout_clk or posedge rst_outclk)
  begin
    if (rst_outclk)
      fill_q <= '0;
    else
      fill_q <= fill_nxt;
  end

  always_ff @(posedge dataout_clk)
  begin
    acc_q <= acc_nxt;
  end

  a_fill_bound: assert property (@(posedge dataout_clk) disable iff (rst_outclk)
    fill_q <= `RX_ACC_DEPTH);

  // a stalled output word must not move, even while new words land above it
  for (genvar i = 0; i < `RX_MAX_SYMS; i++)
  begin : g_stall_chk
    a_out_stable: assert property (@(posedge dataout_clk) disable iff (rst_outclk)
      out_link.valid && !out_link.ready |=>
        out_link.valid && ((i >= int'(words_out)) || $stable(out_link.syms[i])));
  end

endmodule

`default_nettype wire

//--- rx_out_port.sv
/*
  Output side of the width adapter. Takes one word from both gearboxes on the
  same edge, registers it with unused slots zeroed and presents it through a
  four-phase req/ack master. Also registers the configuration error flag.
*/
`timescale 1ns/1ps
`default_nettype none

`include "rx_adapt_defines.svh"

module rx_out_port (
  input  logic                                          dataout_clk,
  input  logic                                          rst_outclk,
  sym_word_if.consumer                                  data_link,
  sym_word_if.consumer                                  stat_link,
  input  logic                                          cfg_error_data,
  input  logic                                          cfg_error_stat,
  output logic                                          out_req,
  input  logic                                          out_ack,
  output rx_adapt_pkg::rx_byte_t   [`RX_MAX_SYMS-1:0]   dataout,
  output rx_adapt_pkg::rx_status_t [`RX_MAX_SYMS-1:0]   statout,
  output rx_adapt_pkg::sym_cnt_t                        words_valid,
  output logic                                          error
);

  logic take;

  // a new word is pulled only after the sink has closed the last handshake
  assign take = data_link.valid && stat_link.valid && !out_req && !out_ack;
  assign data_link.ready = take;
  assign stat_link.ready = take;

  always_ff @(posedge dataout_clk or posedge rst_outclk)
  begin
    if (rst_outclk)
    begin
      out_req     <= 1'b0;
      words_valid <= '0;
      error       <= 1'b0;
    end
    else
    begin
      if (take)
      begin
        out_req     <= 1'b1;
        words_valid <= data_link.cnt;
      end
      else if (out_req && out_ack)
      begin
        out_req <= 1'b0;
      end
      error <= cfg_error_data | cfg_error_stat;
    end
  end

  // slots beyond the word count go out as zero
  always_ff @(posedge dataout_clk)
  begin
    if (take)
    begin
      for (int i = 0; i < `RX_MAX_SYMS; i++)
      begin
        if (i < int'(data_link.cnt))
        begin
          dataout[i] <= data_link.syms[i];
          statout[i] <= stat_link.syms[i];
        end
        else
        begin
          dataout[i] <= '0;
          statout[i] <= '0;
        end
      end
    end
  end

  // both gearboxes must offer their words together and with the same size
  a_links_aligned: assert property (@(posedge dataout_clk) disable iff (rst_outclk)
    data_link.valid == stat_link.valid &&
    (!data_link.valid || data_link.cnt == stat_link.cnt));

  // the sink answers only a request that is up
  a_ack_needs_req: assert property (@(posedge dataout_clk) disable iff (rst_outclk)
    $rose(out_ack) |-> out_req);

endmodule

`default_nettype wire

//--- rx_width_adapter.sv
/*
  Top level of the receive width adapter. Flat decoder-side vectors are
  regrouped per symbol, passed through the input port, two lockstep gearboxes
  and the output port, and flattened again on the way out.
*/
`timescale 1ns/1ps
`default_nettype none

`include "rx_adapt_defines.svh"

module rx_width_adapter (
  input  logic                                      dataout_clk,
  input  logic                                      rst_outclk,
  input  rx_adapt_pkg::sym_cnt_t                    ser_words_in,
  input  rx_adapt_pkg::sym_cnt_t                    ser_words_out,
  input  logic                                      in_req,
  output logic                                      in_ack,
  input  logic [`RX_MAX_SYMS*`RX_SYM_BITS-1:0]      datain,
  input  logic [`RX_MAX_SYMS-1:0]                   datakin,
  input  logic [`RX_MAX_SYMS-1:0]                   disperrin,
  input  logic [`RX_MAX_SYMS-1:0]                   errdetectin,
  input  logic [`RX_MAX_SYMS-1:0]                   patdetin,
  output logic                                      out_req,
  input  logic                                      out_ack,
  output logic [`RX_MAX_SYMS*`RX_SYM_BITS-1:0]      dataout,
  output logic [`RX_MAX_SYMS-1:0]                   datakout,
  output logic [`RX_MAX_SYMS-1:0]                   disperrout,
  output logic [`RX_MAX_SYMS-1:0]                   errdetectout,
  output logic [`RX_MAX_SYMS-1:0]                   patdetout,
  output rx_adapt_pkg::sym_cnt_t                    words_valid,
  output logic                                      error
);

  rx_adapt_pkg::rx_byte_t   [`RX_MAX_SYMS-1:0] datain_syms;
  rx_adapt_pkg::rx_byte_t   [`RX_MAX_SYMS-1:0] dataout_syms;
  rx_adapt_pkg::rx_status_t [`RX_MAX_SYMS-1:0] statin_syms;
  rx_adapt_pkg::rx_status_t [`RX_MAX_SYMS-1:0] statout_syms;
  logic                                        cfg_error_data;
  logic                                        cfg_error_stat;

  sym_word_if #(.sym_t(rx_adapt_pkg::rx_byte_t))   in_data_link ();
  sym_word_if #(.sym_t(rx_adapt_pkg::rx_status_t)) in_stat_link ();
  sym_word_if #(.sym_t(rx_adapt_pkg::rx_byte_t))   out_data_link ();
  sym_word_if #(.sym_t(rx_adapt_pkg::rx_status_t)) out_stat_link ();

  // byte i of the flat bus is symbol i, so the data needs no reordering
  assign datain_syms = datain;
  assign dataout     = dataout_syms;

  for (genvar i = 0; i < `RX_MAX_SYMS; i++)
  begin : g_flags
    assign statin_syms[i] = '{ctrl:     datakin[i],
                              disp_err: disperrin[i],
                              code_err: errdetectin[i],
                              pat_det:  patdetin[i]};
    assign datakout[i]     = statout_syms[i].ctrl;
    assign disperrout[i]   = statout_syms[i].disp_err;
    assign errdetectout[i] = statout_syms[i].code_err;
    assign patdetout[i]    = statout_syms[i].pat_det;
  end

  rx_in_port u_in_port (
    .dataout_clk (dataout_clk),
    .rst_outclk  (rst_outclk),
    .in_req      (in_req),
    .in_ack      (in_ack),
    .datain      (datain_syms),
    .statin      (statin_syms),
    .words_in    (ser_words_in),
    .data_link   (in_data_link),
    .stat_link   (in_stat_link)
  );

  symbol_gearbox #(.sym_t(rx_adapt_pkg::rx_byte_t)) u_data_gearbox (
    .dataout_clk (dataout_clk),
    .rst_outclk  (rst_outclk),
    .words_out   (ser_words_out),
    .in_link     (in_data_link),
    .out_link    (out_data_link),
    .cfg_error   (cfg_error_data)
  );

  symbol_gearbox #(.sym_t(rx_adapt_pkg::rx_status_t)) u_stat_gearbox (
    .dataout_clk (dataout_clk),
    .rst_outclk  (rst_outclk),
    .words_out   (ser_words_out),
    .in_link     (in_stat_link),
    .out_link    (out_stat_link),
    .cfg_error   (cfg_error_stat)
  );

  rx_out_port u_out_port (
    .dataout_clk    (dataout_clk),
    .rst_outclk     (rst_outclk),
    .data_link      (out_data_link),
    .stat_link      (out_stat_link),
    .cfg_error_data (cfg_error_data),
    .cfg_error_stat (cfg_error_stat),
    .out_req        (out_req),
    .out_ack        (out_ack),
    .dataout        (dataout_syms),
    .statout        (statout_syms),
    .words_valid    (words_valid),
    .error          (error)
  );

endmodule

`default_nettype wire

//--- tb_clock_gen.sv
/*
  Clock and power-on reset source for the adapter testbench.
  The reset is held for a fixed number of clock cycles.
*/
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
  parameter int period_ns    = 40,
  parameter int reset_cycles = 2
) (
  output logic clk,
  output logic rst
);

  initial
  begin
    clk = 1'b0;
    forever #(period_ns / 2) clk = ~clk;
  end

  // reset drops just after an edge so it never races the clocked logic
  initial
  begin
    rst = 1'b1;
    repeat (reset_cycles) @(posedge clk);
    #1;
    rst = 1'b0;
  end

endmodule

`default_nettype wire

//--- tb_rx_width_adapter.sv
/*
  Testbench for the receive width adapter. Replays rx_stim.txt, acts as the
  four-phase source and sink, and checks every output word against a queue
  of the symbols that went in.
*/
`timescale 1ns/1ps
`default_nettype none

`include "rx_adapt_defines.svh"

module tb_rx_width_adapter;

  localparam int clk_period = 40;
  // one symbol in the model is four flags followed by the data byte
  localparam int sym_w      = `RX_SYM_BITS + 4;
  // a block drains within one slowest sink handshake per symbol in flight
  localparam int drain_cycles = 8 * (`RX_ACC_DEPTH + 2 * `RX_MAX_SYMS);

  logic                                   dataout_clk;
  logic                                   rst_init;
  logic                                   rst_cfg;
  logic                                   rst_outclk;
  rx_adapt_pkg::sym_cnt_t                 ser_words_in;
  rx_adapt_pkg::sym_cnt_t                 ser_words_out;
  logic                                   in_req;
  logic                                   in_ack;
  logic [`RX_MAX_SYMS*`RX_SYM_BITS-1:0]   datain;
  logic [`RX_MAX_SYMS-1:0]                datakin;
  logic [`RX_MAX_SYMS-1:0]                disperrin;
  logic [`RX_MAX_SYMS-1:0]                errdetectin;
  logic [`RX_MAX_SYMS-1:0]                patdetin;
  logic                                   out_req;
  logic                                   out_ack;
  logic [`RX_MAX_SYMS*`RX_SYM_BITS-1:0]   dataout;
  logic [`RX_MAX_SYMS-1:0]                datakout;
  logic [`RX_MAX_SYMS-1:0]                disperrout;
  logic [`RX_MAX_SYMS-1:0]                errdetectout;
  logic [`RX_MAX_SYMS-1:0]                patdetout;
  rx_adapt_pkg::sym_cnt_t                 words_valid;
  logic                                   error;

  logic [sym_w-1:0] exp_q[$];
  logic [31:0]      lfsr_state;
  int               n_errors;
  int               n_words;
  int               n_records;
  int               words_sent;
  int               cfg_in;
  int               cfg_out;
  logic             cfg_bad;
  logic             saw_error;
  logic             block_open;
  string            test_name;

  tb_clock_gen #(.period_ns(clk_period), .reset_cycles(2)) i_clk_gen (
    .clk (dataout_clk),
    .rst (rst_init)
  );

  assign rst_outclk = rst_init | rst_cfg;

  rx_width_adapter i_dut (
    .dataout_clk   (dataout_clk),
    .rst_outclk    (rst_outclk),
    .ser_words_in  (ser_words_in),
    .ser_words_out (ser_words_out),
    .in_req        (in_req),
    .in_ack        (in_ack),
    .datain        (datain),
    .datakin       (datakin),
    .disperrin     (disperrin),
    .errdetectin   (errdetectin),
    .patdetin      (patdetin),
    .out_req       (out_req),
    .out_ack       (out_ack),
    .dataout       (dataout),
    .datakout      (datakout),
    .disperrout    (disperrout),
    .errdetectout  (errdetectout),
    .patdetout     (patdetout),
    .words_valid   (words_valid),
    .error         (error)
  );

  // taps 32, 22, 2 and 1, new bit enters at the bottom
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic draw_delay(output int d);
    d = 0;
    for (int b = 0; b < 2; b++)
    begin
      lfsr_state = lfsr_next(lfsr_state);
      d = (d << 1) | int'(lfsr_state[0]);
    end
  endtask

  task automatic log_error(input string msg);
    n_errors++;
    $display("%s", msg);
  endtask

  // all driving and sampling happens 1 ns after the rising edge
  task automatic wait_cycle();
    @(posedge dataout_clk);
    #1;
  endtask

  task automatic apply_config(input int a, input int b);
    wait_cycle();
    rst_cfg       = 1'b1;
    // the new configuration lands only once the reset is already in force
    wait_cycle();
    cfg_in        = a;
    cfg_out       = b;
    cfg_bad       = (a == 0) || (a > `RX_MAX_SYMS) || (b == 0) || (b > `RX_MAX_SYMS);
    saw_error     = 1'b0;
    words_sent    = 0;
    test_name     = $sformatf("cfg_%0d_to_%0d", a, b);
    ser_words_in  = rx_adapt_pkg::sym_cnt_t'(a);
    ser_words_out = rx_adapt_pkg::sym_cnt_t'(b);
    wait_cycle();
    rst_cfg       = 1'b0;
    block_open    = 1'b1;
  endtask

  // under a bad configuration only the first word can be handed over
  task automatic send_word(input logic [31:0] d, input logic [3:0] k,
                           input logic [3:0] dp, input logic [3:0] ce,
                           input logic [3:0] pd);
    if (!cfg_bad || words_sent == 0)
    begin
      if (!cfg_bad)
      begin
        for (int i = 0; i < cfg_in; i++)
          exp_q.push_back({k[i], dp[i], ce[i], pd[i], d[8*i +: 8]});
      end
      datain      = d;
      datakin     = k;
      disperrin   = dp;
      errdetectin = ce;
      patdetin    = pd;
      in_req      = 1'b1;
      do wait_cycle(); while (!in_ack);
      // the new word sits in the holding register, behind at most a full
      // accumulator and one output word the sink has not taken yet
      assert (exp_q.size() <= cfg_in + `RX_ACC_DEPTH + cfg_out)
      else log_error($sformatf("%s: in_ack given with %0d symbols in flight",
                               test_name, exp_q.size()));
      wait_cycle();
      in_req = 1'b0;
      do wait_cycle(); while (in_ack);
    end
    if (cfg_bad)
      repeat (4) wait_cycle();
    words_sent++;
  endtask

  task automatic close_block();
    int cycles_left;
    if (block_open)
    begin
      if (cfg_bad)
      begin
        assert (saw_error)
        else log_error($sformatf("%s: error flag never rose under a bad configuration",
                                 test_name));
      end
      else
      begin
        cycles_left = drain_cycles;
        while ((exp_q.size() != 0 || out_req || out_ack) && cycles_left > 0)
        begin
          wait_cycle();
          cycles_left--;
        end
        assert (exp_q.size() == 0)
        else log_error($sformatf("%s: %0d input symbols never came out",
                                 test_name, exp_q.size()));
        assert (!out_req && !out_ack)
        else log_error($sformatf("%s: output handshake still open after the drain time",
                                 test_name));
      end
      exp_q.delete();
    end
  endtask

  task automatic check_word();
    logic [`RX_MAX_SYMS*sym_w-1:0] exp_word;
    logic [`RX_MAX_SYMS*sym_w-1:0] act_word;
    exp_word = '0;
    act_word = '0;
    n_words++;
    assert (int'(words_valid) == cfg_out)
    else log_error($sformatf("MISMATCH %s words_valid: expected %0d, actual %0d",
                             test_name, cfg_out, words_valid));
    assert (exp_q.size() >= cfg_out)
    else log_error($sformatf("%s: output word came with only %0d input symbols pending",
                             test_name, exp_q.size()));
    for (int i = 0; i < `RX_MAX_SYMS; i++)
    begin
      act_word[sym_w*i +: sym_w] = {datakout[i], disperrout[i], errdetectout[i],
                                    patdetout[i], dataout[8*i +: 8]};
      // unused slots are expected as zero
      if (i < cfg_out && exp_q.size() > 0)
        exp_word[sym_w*i +: sym_w] = exp_q.pop_front();
    end
    assert (act_word == exp_word)
    else log_error($sformatf("MISMATCH %s: expected %h, actual %h",
                             test_name, exp_word, act_word));
  endtask

  // returns the kind letter of the next record, or zero at the end of the file
  task automatic next_kind(input int fd, output logic [7:0] kind);
    int               code;
    logic [8*128-1:0] rest;
    kind = "#";
    while (kind == "#")
    begin
      code = $fscanf(fd, " %c", kind);
      if (code != 1)
        kind = 8'h00;
      else if (kind == "#")
        code = $fgets(rest, fd);
    end
  endtask

  task automatic run_stimulus();
    int               fd;
    int               code;
    int               a;
    int               b;
    logic [7:0]       kind;
    logic [8*128-1:0] rest;
    logic [31:0]      w_data;
    logic [3:0]       w_k;
    logic [3:0]       w_dp;
    logic [3:0]       w_ce;
    logic [3:0]       w_pd;
    fd = $fopen("rx_stim.txt", "r");
    if (fd == 0)
    begin
      log_error("cannot open rx_stim.txt for reading");
    end
    else
    begin
      // a first pass only counts the records to size the watchdog
      next_kind(fd, kind);
      while (kind != 8'h00)
      begin
        code = $fgets(rest, fd);
        if (kind == "C" || kind == "W")
          n_records++;
        next_kind(fd, kind);
      end
      $fclose(fd);
      fd = $fopen("rx_stim.txt", "r");
      next_kind(fd, kind);
      while (kind != 8'h00)
      begin
        if (kind == "C")
        begin
          code = $fscanf(fd, "%d %d", a, b);
          close_block();
          apply_config(a, b);
        end
        else if (kind == "W")
        begin
          code = $fscanf(fd, "%h %h %h %h %h", w_data, w_k, w_dp, w_ce, w_pd);
          send_word(w_data, w_k, w_dp, w_ce, w_pd);
        end
        else
        begin
          log_error("stim file holds a record of unknown kind");
          code = $fgets(rest, fd);
        end
        next_kind(fd, kind);
      end
      close_block();
      $fclose(fd);
    end
  endtask

  initial
  begin : main
    in_req        = 1'b0;
    out_ack       = 1'b0;
    datain        = '0;
    datakin       = '0;
    disperrin     = '0;
    errdetectin   = '0;
    patdetin      = '0;
    ser_words_in  = rx_adapt_pkg::sym_cnt_t'(4);
    ser_words_out = rx_adapt_pkg::sym_cnt_t'(4);
    rst_cfg       = 1'b0;
    cfg_in        = 4;
    cfg_out       = 4;
    cfg_bad       = 1'b0;
    saw_error     = 1'b0;
    block_open    = 1'b0;
    n_errors      = 0;
    n_words       = 0;
    n_records     = 0;
    words_sent    = 0;
    test_name     = "startup";
    lfsr_state    = 32'hfba4_d92a;
    wait (!rst_init);
    run_stimulus();
    $display("checked %0d output words, %0d errors", n_words, n_errors);
    if (n_errors == 0)
      $display("Test OK");
    else
      $display("Test FAILED");
    $finish;
  end

  // sink side of the output handshake, answering after 0 to 3 cycles
  initial
  begin : sink
    int delay;
    forever
    begin
      wait_cycle();
      if (out_req && !out_ack)
      begin
        check_word();
        draw_delay(delay);
        repeat (delay) wait_cycle();
        out_ack = 1'b1;
        do wait_cycle(); while (out_req);
        out_ack = 1'b0;
      end
    end
  end

  // error must track the configuration and a bad one must block all output
  initial
  begin : cfg_monitor
    forever
    begin
      wait_cycle();
      if (!rst_outclk)
      begin
        if (cfg_bad)
        begin
          assert (!out_req)
          else log_error($sformatf("%s: out_req rose under a bad configuration", test_name));
          if (error)
            saw_error = 1'b1;
        end
        else
        begin
          assert (!error)
          else log_error($sformatf("%s: error flag high under a valid configuration",
                                   test_name));
        end
      end
    end
  end

  initial
  begin : watchdog
    wait (n_records > 0);
    repeat (40 * n_records + 200) @(posedge dataout_clk);
    $display("watchdog expired after %0d cycles with stimulus still running",
             40 * n_records + 200);
    $display("Test FAILED");
    $finish;
  end

endmodule

`default_nettype wire

//--- rx_stim.txt
# C <symbols in> <symbols out> resets the adapter and sets a new configuration
# W <data hex> <ctrl> <disp err> <code err> <pat det> with flag bit i for symbol i
C 4 4
W 03020100 1 0 0 0
W 07060504 2 4 8 1
W bc1c3c5c f 0 3 c
C 1 1
W 000000bc 1 0 0 1
W 0000004a 0 1 1 0
C 4 1
W 13121110 1 2 4 8
W 17161514 8 4 2 1
W 1b1a1918 3 0 c 5
W 1f1e1d1c a 5 0 f
C 1 4
W 00000021 1 0 0 0
W 00000022 0 1 0 0
W 00000023 0 0 1 0
W 00000024 0 0 0 1
W 00000025 1 1 0 0
W 00000026 0 0 1 1
W 00000027 1 0 1 0
W 00000028 0 1 0 1
C 3 2
W ff323130 d 2 1 4
W 00353433 2 5 4 1
W 00383736 7 0 2 6
W 003b3a39 0 7 6 2
C 5 2
W 44434241 f f f f
W 48474645 1 1 1 1
C 2 0
W 00005251 3 0 0 3
W 00005453 0 3 3 0
C 4 4
W fbf7f1e0 9 6 a 5
W 5a5a5a5a 6 9 5 a

//--- vlog.f
+incdir+.
rx_adapt_pkg.sv
sym_word_if.sv
rx_in_port.sv
symbol_gearbox.sv
rx_out_port.sv
rx_width_adapter.sv
tb_clock_gen.sv
tb_rx_width_adapter.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the width adapter testbench with Verilator, runs it and checks the log.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  -f vlog.f --top-module tb_rx_width_adapter -Mdir obj_dir

./obj_dir/Vtb_rx_width_adapter | tee sim.log

# the run passes only if the testbench printed its pass line
grep -qx "Test OK" sim.log
